//--- common/lane_pkg.sv
package lane_pkg;

	// Bytes carried per lane word
	localparam int LANE_BYTES = 8;

	typedef logic [7:0] lane_byte_t;

	// Byte 0 sits in bits 7:0 and is the first byte on the wire.
	// Inside a byte the LSB goes out first.
	typedef lane_byte_t [LANE_BYTES-1:0] lane_word_t;

	// Frame start offset within the first lane word
	typedef logic [2:0] lane_offset_t;

endpackage

//--- common/crc_pkg.sv
package crc_pkg;

	// Register width and the width of one parallel step
	localparam int CRC_WIDTH = 32;
	localparam int STEP_BITS = 64;

	// IEEE 802.3 generator polynomial in normal (MSB first) form
	localparam logic [CRC_WIDTH-1:0] CRC_POLY = 32'h04c1_1db7;

	typedef logic [CRC_WIDTH-1:0] crc_t;

	// Start value per byte offset.
	// With offset k the first lane word carries 8-k zero bytes ahead of the
	// frame data. Each seed is the state that those zero bytes carry into the
	// all-ones start value, so the zero pad drops out of the result.
	function automatic crc_t crc_seed(input logic [2:0] offset);
		crc_t seed;
		case (offset)
			3'd0:
			begin
				seed = 32'hffff_ffff;
			end
			3'd1:
			begin
				seed = 32'h955a_6162;
			end
			3'd2:
			begin
				seed = 32'h68b9_32f5;
			end
			3'd3:
			begin
				seed = 32'h339f_de2f;
			end
			3'd4:
			begin
				seed = 32'h46af_6449;
			end
			3'd5:
			begin
				seed = 32'h8164_74c5;
			end
			3'd6:
			begin
				seed = 32'h09b9_3859;
			end
			default:
			begin
				seed = 32'h9bf1_a90f;
			end
		endcase
		return seed;
	endfunction

	// One serial LFSR shift of the normal form register
	function automatic crc_t crc_step1(input logic d, input crc_t c);
		logic fb;
		crc_t shifted;
		fb = c[CRC_WIDTH-1] ^ d;
		shifted = {c[CRC_WIDTH-2:0], 1'b0};
		if (fb)
		begin
			shifted = shifted ^ CRC_POLY;
		end
		return shifted;
	endfunction

	// Parallel next state over 64 data bits.
	// Bit 63 enters the register first and bit 0 last. The loop unrolls into
	// one XOR network per register bit, the same network as a tabulated
	// 64-bit step.
	function automatic crc_t crc_step64(
		input logic [STEP_BITS-1:0] data,
		input crc_t crc
	);
		crc_t c;
		c = crc;
		for (int i = STEP_BITS - 1; i >= 0; i--)
		begin
			c = crc_step1(data[i], c);
		end
		return c;
	endfunction

endpackage

//--- source/crc_frame_ctrl.sv
`timescale 1ns/1ps

module crc_frame_ctrl
(
	input logic clk,
	input logic rst_,
	input logic we_,
	input logic last_,
	input logic clr_,
	output logic load,
	output logic update,
	output logic crc32_vld_
);

	// One-hot state bits
	localparam int IDLE_BIT = 0;
	localparam int CALC_BIT = 1;
	localparam int WAIT_BIT = 2;

	localparam logic [2:0] IDLE = 3'b001 << IDLE_BIT;
	localparam logic [2:0] CALC = 3'b001 << CALC_BIT;
	localparam logic [2:0] WAIT_CLR = 3'b001 << WAIT_BIT;

	logic [2:0] state;
	logic [2:0] state_nxt;
	logic last_reg_;

	always_comb
	begin
		state_nxt = state;
		case (state)
			IDLE:
			begin
				if (!we_)
				begin
					state_nxt = CALC;
				end
			end
			CALC:
			begin
				// Last word has reached the aligner output
				if (!last_reg_)
				begin
					state_nxt = WAIT_CLR;
				end
			end
			WAIT_CLR:
			begin
				if (!clr_)
				begin
					state_nxt = IDLE;
				end
			end
			default:
			begin
				state_nxt = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst_)
		begin
			state <= IDLE;
			last_reg_ <= 1'b1;
			crc32_vld_ <= 1'b1;
		end
		else
		begin
			state <= state_nxt;
			last_reg_ <= last_;
			// Valid lands with the final engine step
			crc32_vld_ <= last_reg_;
		end
	end

	assign load = state[IDLE_BIT];
	assign update = state[CALC_BIT];

endmodule

//--- source/lane_aligner.sv
`timescale 1ns/1ps

module lane_aligner
(
	input logic clk,
	input lane_pkg::lane_word_t cdin,
	input lane_pkg::lane_offset_t bytes,
	input logic load,
	output lane_pkg::lane_word_t aligned
);

	lane_pkg::lane_word_t prev;
	lane_pkg::lane_word_t spliced;

	// Offset k takes the upper 8-k bytes of the last word into the low lanes
	// and the low k bytes of the current word into the top lanes.
	// On the first word the low lanes are zero, and the engine seed covers them.
	always_comb
	begin
		int k;
		k = int'(bytes);
		spliced = cdin;
		if (k != 0)
		begin
			for (int i = 0; i < lane_pkg::LANE_BYTES; i++)
			begin
				if (i < lane_pkg::LANE_BYTES - k)
				begin
					if (load)
					begin
						spliced[i] = '0;
					end
					else
					begin
						spliced[i] = prev[i + k];
					end
				end
				else
				begin
					spliced[i] = cdin[i + k - lane_pkg::LANE_BYTES];
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		prev <= cdin;
		aligned <= spliced;
	end

endmodule

//--- crc/crc32_engine.sv
`timescale 1ns/1ps

module crc32_engine
(
	input logic clk,
	input lane_pkg::lane_offset_t bytes,
	input logic load,
	input logic update,
	input lane_pkg::lane_word_t aligned,
	output crc_pkg::crc_t crc32
);

	crc_pkg::crc_t crc_q;
	logic [crc_pkg::STEP_BITS-1:0] data_flat;
	logic [crc_pkg::STEP_BITS-1:0] data_rev;

	assign data_flat = aligned;

	// The wire sends byte 0 bit 0 first, and the step takes its first bit
	// at the MSB, so the whole word is mirrored
	always_comb
	begin
		for (int i = 0; i < crc_pkg::STEP_BITS; i++)
		begin
			data_rev[crc_pkg::STEP_BITS-1-i] = data_flat[i];
		end
	end

	// Seed while idle, one 64-bit step per cycle while calculating
	always_ff @(posedge clk)
	begin
		if (load)
		begin
			crc_q <= crc_pkg::crc_seed(bytes);
		end
		else if (update)
		begin
			crc_q <= crc_pkg::crc_step64(data_rev, crc_q);
		end
	end

	// FCS is the register complemented and reflected.
	// Each byte comes out bit-reversed, and the byte order is reversed too,
	// which gives the usual reflected CRC-32 value.
	always_comb
	begin
		for (int j = 0; j < crc_pkg::CRC_WIDTH / 8; j++)
		begin
			for (int b = 0; b < 8; b++)
			begin
				crc32[8*j + b] = ~crc_q[crc_pkg::CRC_WIDTH - 1 - (8*j + b)];
			end
		end
	end

endmodule

//--- source/tx_crc32x64.sv
`timescale 1ns/1ps

module tx_crc32x64
(
	input logic clk,
	input logic rst_,
	input logic clr_,
	input lane_pkg::lane_offset_t bytes,
	input logic we_,
	input logic last_,
	input lane_pkg::lane_word_t cdin,
	output crc_pkg::crc_t crc32,
	output logic crc32_vld_
);

	logic load;
	logic update;
	lane_pkg::lane_word_t aligned;

	// Sequencing and valid pulse
	crc_frame_ctrl crc_frame_ctrl_i
	(
		.clk(clk),
		.rst_(rst_),
		.we_(we_),
		.last_(last_),
		.clr_(clr_),
		.load(load),
		.update(update),
		.crc32_vld_(crc32_vld_)
	);

	// First pipeline stage, byte realignment by offset
	lane_aligner lane_aligner_i
	(
		.clk(clk),
		.cdin(cdin),
		.bytes(bytes),
		.load(load),
		.aligned(aligned)
	);

	// Second stage, CRC state and FCS output
	crc32_engine crc32_engine_i
	(
		.clk(clk),
		.bytes(bytes),
		.load(load),
		.update(update),
		.aligned(aligned),
		.crc32(crc32)
	);

endmodule

//--- tests/tx_crc32x64_assertions.sv
`timescale 1ns/1ps

module tx_crc32x64_assertions
(
	input logic clk,
	input logic rst_,
	input logic last_,
	input logic load,
	input logic update,
	input logic crc32_vld_
);

	int fail_count = 0;

	// Idle and calculate are exclusive
	load_update_exclusive: assert property (@(posedge clk) disable iff (!rst_)
		!(load && update))
	else
	begin
		fail_count++;
		$error("load and update are high in the same cycle");
	end

	// The valid strobe is a single cycle pulse
	vld_single_pulse: assert property (@(posedge clk) disable iff (!rst_)
		!crc32_vld_ |=> crc32_vld_)
	else
	begin
		fail_count++;
		$error("crc32_vld_ stayed low for more than one cycle");
	end

	// Pulse lands two cycles after the last word
	vld_after_last: assert property (@(posedge clk) disable iff (!rst_)
		(!last_ && update) |-> ##2 !crc32_vld_)
	else
	begin
		fail_count++;
		$error("crc32_vld_ did not go low two cycles after last_");
	end

endmodule

bind crc_frame_ctrl tx_crc32x64_assertions ctrl_assertions_i
(
	.clk(clk),
	.rst_(rst_),
	.last_(last_),
	.load(load),
	.update(update),
	.crc32_vld_(crc32_vld_)
);

//--- tests/tb_tx_crc32x64.sv
`timescale 1ns/1ps

module tb_tx_crc32x64;

	// Longest run of each test in cycles, frames included
	localparam int RESET_CYCLES = 4;
	localparam int IDLE_CYCLES = 20;
	localparam int STRING_CYCLES = 8;
	localparam int ALIGNED_CYCLES = 8 * (8 + 5);
	localparam int OFFSET_CYCLES = 14 * (5 + 5);
	localparam int TIMING_CYCLES = 30;
	localparam int B2B_CYCLES = 7 * (4 + 4);
	localparam int TOTAL_CYCLES = RESET_CYCLES + IDLE_CYCLES + STRING_CYCLES + ALIGNED_CYCLES
		+ OFFSET_CYCLES + TIMING_CYCLES + B2B_CYCLES;
	localparam int TIMEOUT_CYCLES = 2 * TOTAL_CYCLES + 50;

	logic clk = 1'b0;
	logic rst_;
	logic clr_;
	logic we_;
	logic last_;
	lane_pkg::lane_offset_t bytes;
	lane_pkg::lane_word_t cdin;
	crc_pkg::crc_t crc32;
	logic crc32_vld_;

	logic [63:0] rng_state;
	int error_count;
	int test_count;
	lane_pkg::lane_word_t frame_words[$];
	lane_pkg::lane_byte_t frame_bytes[$];

	tx_crc32x64 tx_crc32x64_i
	(
		.clk(clk),
		.rst_(rst_),
		.clr_(clr_),
		.bytes(bytes),
		.we_(we_),
		.last_(last_),
		.cdin(cdin),
		.crc32(crc32),
		.crc32_vld_(crc32_vld_)
	);

	always #50 clk = ~clk;

	function automatic logic [63:0] xorshift64(input logic [63:0] x);
		logic [63:0] y;
		y = x;
		y = y ^ (y << 13);
		y = y ^ (y >> 7);
		y = y ^ (y << 17);
		return y;
	endfunction

	// Bitwise reflected CRC-32 over the bytes in wire order
	function automatic crc_pkg::crc_t ref_crc32(input lane_pkg::lane_byte_t data[$]);
		crc_pkg::crc_t c;
		c = '1;
		foreach (data[i])
		begin
			c = c ^ {24'd0, data[i]};
			for (int b = 0; b < 8; b++)
			begin
				if (c[0])
				begin
					c = (c >> 1) ^ 32'hedb8_8320;
				end
				else
				begin
					c = c >> 1;
				end
			end
		end
		return ~c;
	endfunction

	task automatic random_word(output lane_pkg::lane_word_t w);
		rng_state = xorshift64(rng_state);
		w = rng_state;
	endtask

	task automatic random_range(input int lo, input int hi, output int v);
		rng_state = xorshift64(rng_state);
		v = lo + (int'(rng_state[15:0]) % (hi - lo + 1));
	endtask

	task automatic tick();
		@(posedge clk);
		#1;
	endtask

	task automatic compare_crc(input string name, input crc_pkg::crc_t got,
		input crc_pkg::crc_t exp);
		if (got !== exp)
		begin
			$display("Mismatch %s: got %h, expected %h", name, got, exp);
			error_count++;
		end
	endtask

	task automatic compare_vld(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("Mismatch %s: got %h, expected %h", name, got, exp);
			error_count++;
		end
	endtask

	task automatic random_frame(input int nwords);
		lane_pkg::lane_word_t w;
		frame_words.delete();
		for (int i = 0; i < nwords; i++)
		begin
			random_word(w);
			frame_words.push_back(w);
		end
	endtask

	// Wire bytes of the frame; a last word at offset k adds only k bytes
	task automatic derive_bytes(input lane_pkg::lane_offset_t off);
		int count;
		frame_bytes.delete();
		foreach (frame_words[w])
		begin
			count = lane_pkg::LANE_BYTES;
			if (off != 0 && w == frame_words.size() - 1)
			begin
				count = int'(off);
			end
			for (int b = 0; b < count; b++)
			begin
				frame_bytes.push_back(frame_words[w][b]);
			end
		end
	endtask

	// Drives frame_words from the current cycle and checks the pulse at n+2
	task automatic send_frame(input lane_pkg::lane_offset_t off, input crc_pkg::crc_t expected);
		int last_w;
		lane_pkg::lane_word_t w;
		last_w = frame_words.size() - 1;
		for (int i = 0; i <= last_w; i++)
		begin
			compare_vld("crc32_vld_ during frame", crc32_vld_, 1'b1);
			bytes = off;
			cdin = frame_words[i];
			we_ = (i == 0) ? 1'b0 : 1'b1;
			last_ = (i == last_w) ? 1'b0 : 1'b1;
			tick();
		end
		we_ = 1'b1;
		last_ = 1'b1;
		random_word(w);
		cdin = w;
		compare_vld("crc32_vld_ at n+1", crc32_vld_, 1'b1);
		tick();
		compare_vld("crc32_vld_ at n+2", crc32_vld_, 1'b0);
		compare_crc("crc32", crc32, expected);
		tick();
		compare_vld("crc32_vld_ at n+3", crc32_vld_, 1'b1);
		compare_crc("crc32 after pulse", crc32, expected);
	endtask

	task automatic clear_frame();
		clr_ = 1'b0;
		tick();
		clr_ = 1'b1;
	endtask

	task automatic report_test(input string name, input int errors_before);
		test_count++;
		$display("%-20s errors: %0d", name, error_count - errors_before);
	endtask

	task automatic test_reset_idle();
		int e;
		e = error_count;
		for (int i = 0; i < IDLE_CYCLES; i++)
		begin
			tick();
			compare_vld("crc32_vld_ idle", crc32_vld_, 1'b1);
		end
		report_test("reset_idle", e);
	endtask

	task automatic test_check_string();
		int e;
		lane_pkg::lane_word_t w;
		e = error_count;
		frame_words.delete();
		for (int i = 0; i < lane_pkg::LANE_BYTES; i++)
		begin
			w[i] = 8'h31 + 8'(i);
		end
		frame_words.push_back(w);
		random_word(w);
		w[0] = 8'h39;
		frame_words.push_back(w);
		send_frame(3'd1, 32'hcbf4_3926);
		clear_frame();
		report_test("check_string", e);
	endtask

	task automatic test_aligned_frames();
		int e;
		e = error_count;
		for (int n = 1; n <= 8; n++)
		begin
			random_frame(n);
			derive_bytes(3'd0);
			send_frame(3'd0, ref_crc32(frame_bytes));
			clear_frame();
			tick();
		end
		report_test("aligned_frames", e);
	endtask

	task automatic test_offset_frames();
		int e;
		int n;
		e = error_count;
		for (int k = 1; k < lane_pkg::LANE_BYTES; k++)
		begin
			for (int rep = 0; rep < 2; rep++)
			begin
				random_range(1, 5, n);
				random_frame(n);
				derive_bytes(3'(k));
				send_frame(3'(k), ref_crc32(frame_bytes));
				clear_frame();
				tick();
			end
		end
		report_test("offset_frames", e);
	endtask

	task automatic test_valid_timing();
		int e;
		crc_pkg::crc_t expected;
		lane_pkg::lane_word_t w;
		e = error_count;
		random_frame(3);
		derive_bytes(3'd4);
		expected = ref_crc32(frame_bytes);
		send_frame(3'd4, expected);
		// A we_ strobe while waiting for clr_ must leave the result alone
		for (int i = 0; i < 6; i++)
		begin
			random_word(w);
			cdin = w;
			we_ = (i == 2) ? 1'b0 : 1'b1;
			tick();
			compare_crc("crc32 held in wait", crc32, expected);
			compare_vld("crc32_vld_ in wait", crc32_vld_, 1'b1);
		end
		we_ = 1'b1;
		clear_frame();
		compare_vld("crc32_vld_ after clear", crc32_vld_, 1'b1);
		random_frame(2);
		derive_bytes(3'd0);
		send_frame(3'd0, ref_crc32(frame_bytes));
		clear_frame();
		report_test("valid_timing", e);
	endtask

	task automatic test_back_to_back();
		int e;
		int n;
		lane_pkg::lane_offset_t offsets[7];
		e = error_count;
		offsets = '{3'd3, 3'd0, 3'd5, 3'd7, 3'd1, 3'd6, 3'd2};
		foreach (offsets[i])
		begin
			random_range(1, 4, n);
			random_frame(n);
			derive_bytes(offsets[i]);
			send_frame(offsets[i], ref_crc32(frame_bytes));
			clear_frame();
		end
		report_test("back_to_back", e);
	endtask

	initial
	begin : watchdog
		int n;
		n = 0;
		while (n < TIMEOUT_CYCLES)
		begin
			@(posedge clk);
			n++;
		end
		$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("TEST FAILED");
		$finish;
	end

	initial
	begin
		int assert_fails;
		rng_state = 64'd63;
		error_count = 0;
		test_count = 0;
		rst_ = 1'b0;
		clr_ = 1'b1;
		we_ = 1'b1;
		last_ = 1'b1;
		bytes = '0;
		cdin = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst_ = 1'b1;

		test_reset_idle();
		test_check_string();
		test_aligned_frames();
		test_offset_frames();
		test_valid_timing();
		test_back_to_back();

		assert_fails = tx_crc32x64_i.crc_frame_ctrl_i.ctrl_assertions_i.fail_count;
		$display("Summary: %0d tests, %0d check errors, %0d assertion failures",
			test_count, error_count, assert_fails);
		if (error_count == 0 && assert_fails == 0)
		begin
			$display("TEST PASSED");
		end
		else
		begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

//--- verilog.f
common/lane_pkg.sv
common/crc_pkg.sv
source/crc_frame_ctrl.sv
source/lane_aligner.sv
crc/crc32_engine.sv
source/tx_crc32x64.sv
tests/tx_crc32x64_assertions.sv
tests/tb_tx_crc32x64.sv

//--- Makefile
TOOL       = verilator
TOP        = tb_tx_crc32x64
FILELIST   = verilog.f
LINT_FLAGS = --lint-only -Wall --timing
SIM_FLAGS  = --binary --timing --assert
RUN_FLAGS  = +verilator+error+limit+1000
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_TEXT  = TEST PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
